// ==== logic/vec_io_defines.svh ====
`ifndef VEC_IO_DEFINES_SVH
`define VEC_IO_DEFINES_SVH

// ---------------------------------------------------------------------------
// I/O port map, low address byte only
// ---------------------------------------------------------------------------

// Joystick control port occupies the pair 04h/05h
`define VEC_JOY_CTRL 8'h04
`define VEC_JOY_P 8'h06
`define VEC_JOY_PU 8'h07
`define VEC_JOY_A 8'h0E
`define VEC_JOY_B 8'h0F
`define VEC_EDSK 8'h10
// Covox shares 07h with the PU read port, writes only
`define VEC_COVOX 8'h07

// ---------------------------------------------------------------------------
// E-disk control register bits
// ---------------------------------------------------------------------------

// Window at E000h-FFFFh
`define VEC_ED_WIN_HI 7
// Window at 8000h-9FFFh
`define VEC_ED_WIN_LO 6
`define VEC_ED_RAM_EN 5
`define VEC_ED_STACK_EN 4

// Covox write window after boot, in clk_sys cycles
`define VEC_COVOX_TIMEOUT 200000000

`endif

// ==== logic/vec_io_pkg.sv ====
`default_nettype none

package vec_io_pkg;

	// -----------------------------------------------------------------------
	// Bus types
	// -----------------------------------------------------------------------

	// One data byte on the 8080 bus
	typedef logic [7:0] byte_t;

	// Full CPU address, ports decode only bits 7:0
	typedef logic [15:0] cpu_addr_t;

	// RAM bank number
	// 0 is main RAM, 1 to 4 select one of the E-disk pages
	typedef logic [2:0] ed_page_t;

	// -----------------------------------------------------------------------
	// 8080 status word
	// -----------------------------------------------------------------------

	// Latched from the data bus at SYNC
	// Bit 0 is int_ack, bit 7 is ram_read
	typedef struct packed {
		logic ram_read;
		logic io_read;
		logic m1;
		logic io_write;
		logic halt_ack;
		// Stack access, PUSH/POP/CALL/RET
		logic io_stack;
		// Low on memory and I/O writes
		logic write_n;
		logic int_ack;
	} status_word_t;

endpackage

`default_nettype wire

// ==== logic/bus_ctrl.sv ====
`default_nettype none

`include "vec_io_defines.svh"

module bus_ctrl (
	input logic clk_sys,
	input logic cold_reset,
	input vec_io_pkg::cpu_addr_t addr_i,
	input vec_io_pkg::byte_t cpu_dout_i,
	input logic cpu_sync_i,
	input logic cpu_rd_i,
	input logic cpu_wr_n_i,
	input vec_io_pkg::byte_t joy_p_i,
	input vec_io_pkg::byte_t joy_pu_i,
	input vec_io_pkg::byte_t joy_a_fmt_i,
	input vec_io_pkg::byte_t joy_b_fmt_i,
	output vec_io_pkg::byte_t io_data_o,
	output logic mreq_o,
	output logic int_ack_o,
	output logic mem_access_o,
	output logic io_stack_o,
	output logic edsk_we_o,
	output logic joy_we_o,
	output logic joy_addr0_o,
	output logic vox_we_o
);

	localparam logic [7:0] JOY_CTRL_PORT = `VEC_JOY_CTRL;
	localparam logic [7:0] EDSK_PORT = `VEC_EDSK;
	localparam logic [7:0] COVOX_PORT = `VEC_COVOX;

	vec_io_pkg::status_word_t status_q;
	logic sync_q;
	logic io_wr;
	logic io_rd;
	// Bit 0 E-disk, bit 1 joystick, bit 2 Covox
	logic [2:0] wr_sel;
	logic [2:0] wr_seen_q;
	logic [2:0] wr_pulse_q;
	logic joy_addr0_q;

	// ------------------------------------------------------------------------
	// Status word capture on the rising edge of SYNC
	// ------------------------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			sync_q <= 1'b0;
			status_q <= '0;
		end else begin
			sync_q <= cpu_sync_i;
			if (cpu_sync_i && !sync_q)
				status_q <= vec_io_pkg::status_word_t'(cpu_dout_i);
		end
	end

	// Memory cycle when reading RAM or writing, but not an I/O cycle
	assign mem_access_o = status_q.ram_read | ~status_q.write_n;
	assign mreq_o = mem_access_o & ~status_q.io_write & ~status_q.io_read;
	assign int_ack_o = status_q.int_ack;
	assign io_stack_o = status_q.io_stack;

	assign io_wr = status_q.io_write & ~cpu_wr_n_i;
	assign io_rd = status_q.io_read & cpu_rd_i;

	// ------------------------------------------------------------------------
	// Write decode and one-shot strobes
	// ------------------------------------------------------------------------

	assign wr_sel[0] = io_wr && (addr_i[7:0] == EDSK_PORT);
	assign wr_sel[1] = io_wr && (addr_i[7:1] == JOY_CTRL_PORT[7:1]);
	assign wr_sel[2] = io_wr && (addr_i[7:0] == COVOX_PORT);

	// A held write level yields a single pulse, one cycle late
	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			wr_seen_q <= '0;
			wr_pulse_q <= '0;
		end else begin
			wr_seen_q <= wr_sel;
			wr_pulse_q <= wr_sel & ~wr_seen_q;
		end
	end

	// Port half of the control pair, aligned with the strobe
	always_ff @(posedge clk_sys) begin
		if (cold_reset)
			joy_addr0_q <= 1'b0;
		else
			joy_addr0_q <= addr_i[0];
	end

	assign edsk_we_o = wr_pulse_q[0];
	assign joy_we_o = wr_pulse_q[1];
	assign vox_we_o = wr_pulse_q[2];
	assign joy_addr0_o = joy_addr0_q;

	// Read mux, unmapped ports float high
	always_comb begin
		io_data_o = 8'hFF;
		if (io_rd) begin
			case (addr_i[7:0])
				JOY_CTRL_PORT, JOY_CTRL_PORT | 8'h01: io_data_o = 8'h00;
				`VEC_JOY_P: io_data_o = joy_p_i;
				`VEC_JOY_PU: io_data_o = joy_pu_i;
				`VEC_JOY_A: io_data_o = joy_a_fmt_i;
				`VEC_JOY_B: io_data_o = joy_b_fmt_i;
				default: io_data_o = 8'hFF;
			endcase
		end
	end

	// Strobes from different ports never overlap
	assert property (@(posedge clk_sys) disable iff (cold_reset) $onehot0(wr_pulse_q))
		else $error("bus_ctrl: more than one write strobe active");

endmodule

`default_nettype wire

// ==== logic/edisk_mapper.sv ====
`default_nettype none

`include "vec_io_defines.svh"

module edisk_mapper (
	input logic clk_sys,
	input logic cold_reset,
	input vec_io_pkg::cpu_addr_t addr_i,
	input vec_io_pkg::byte_t cpu_dout_i,
	input logic edsk_we_i,
	input logic mem_access_i,
	input logic io_stack_i,
	output vec_io_pkg::ed_page_t ed_page_o
);

	vec_io_pkg::byte_t ed_reg_q;
	logic ed_win;
	logic ed_ram;
	logic ed_stack;

	always_ff @(posedge clk_sys) begin
		if (cold_reset)
			ed_reg_q <= '0;
		else if (edsk_we_i)
			ed_reg_q <= cpu_dout_i;
	end

	// ------------------------------------------------------------------------
	// Window decode
	// ------------------------------------------------------------------------

	// A000h-DFFFh always, E000h-FFFFh and 8000h-9FFFh on request
	assign ed_win = addr_i[15] & (
		(addr_i[14] ^ addr_i[13]) |
		(ed_reg_q[`VEC_ED_WIN_HI] & addr_i[14] & addr_i[13]) |
		(ed_reg_q[`VEC_ED_WIN_LO] & ~addr_i[14] & ~addr_i[13]));

	assign ed_ram = ed_reg_q[`VEC_ED_RAM_EN] & ed_win & mem_access_i;
	assign ed_stack = ed_reg_q[`VEC_ED_STACK_EN] & io_stack_i & mem_access_i;

	// Stack mapping wins over the window mapping
	always_comb begin
		if (ed_stack)
			ed_page_o = vec_io_pkg::ed_page_t'({1'b0, ed_reg_q[3:2]}) + 3'd1;
		else if (ed_ram)
			ed_page_o = vec_io_pkg::ed_page_t'({1'b0, ed_reg_q[1:0]}) + 3'd1;
		else
			ed_page_o = '0;
	end

	// Page selection only during a memory cycle
	assert property (@(posedge clk_sys) disable iff (cold_reset)
		(ed_page_o != '0) |-> mem_access_i)
		else $error("edisk_mapper: E-disk page outside a memory cycle");

endmodule

`default_nettype wire

// ==== logic/joy_ports.sv ====
`default_nettype none

module joy_ports (
	input logic clk_sys,
	input logic cold_reset,
	input vec_io_pkg::byte_t cpu_dout_i,
	input logic joy_we_i,
	input logic joy_addr0_i,
	input vec_io_pkg::byte_t joy_a_i,
	input vec_io_pkg::byte_t joy_b_i,
	output vec_io_pkg::byte_t joy_p_o,
	output vec_io_pkg::byte_t joy_pu_o,
	output vec_io_pkg::byte_t joy_a_fmt_o,
	output vec_io_pkg::byte_t joy_b_fmt_o
);

	vec_io_pkg::byte_t joy_port_q;
	vec_io_pkg::byte_t joy_pu;

	// ------------------------------------------------------------------------
	// Control port, 05h full write, 04h bit set/reset
	// ------------------------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			joy_port_q <= '0;
		end else if (joy_we_i) begin
			if (joy_addr0_i)
				joy_port_q <= cpu_dout_i;
			else if (!cpu_dout_i[7])
				joy_port_q[cpu_dout_i[3:1]] <= cpu_dout_i[0];
		end
	end

	// ------------------------------------------------------------------------
	// Read formatting
	// ------------------------------------------------------------------------

	// Active low, Fire2 Fire1 x x Up Down Left Right
	assign joy_a_fmt_o = ~{joy_a_i[5], joy_a_i[4], 2'b00, joy_a_i[3:0]};
	assign joy_b_fmt_o = ~{joy_b_i[5], joy_b_i[4], 2'b00, joy_b_i[3:0]};

	// PU port merges both sticks, active high
	assign joy_pu = joy_a_i | joy_b_i;
	assign joy_pu_o = {joy_pu[3], joy_pu[0], joy_pu[2], joy_pu[1],
		joy_pu[4], joy_pu[5], 2'b00};

	// Stick selection for the P port
	always_comb begin
		case (joy_port_q[6:5])
			2'b00: joy_p_o = joy_a_fmt_o & joy_b_fmt_o;
			2'b01: joy_p_o = joy_a_fmt_o;
			2'b10: joy_p_o = joy_b_fmt_o;
			default: joy_p_o = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/covox_dac.sv ====
`default_nettype none

`include "vec_io_defines.svh"

module covox_dac #(
	parameter int unsigned TIMEOUT = `VEC_COVOX_TIMEOUT
) (
	input logic clk_sys,
	input logic cold_reset,
	input logic rom_enable_i,
	input vec_io_pkg::byte_t cpu_dout_i,
	input logic vox_we_i,
	output vec_io_pkg::byte_t covox_o
);

	localparam int CNT_W = $clog2(TIMEOUT + 1);

	logic [CNT_W-1:0] count_q;
	vec_io_pkg::byte_t sample_q;
	logic window_open;

	// ------------------------------------------------------------------------
	// Write window countdown
	// ------------------------------------------------------------------------

	// Held full while the boot ROM is mapped in
	always_ff @(posedge clk_sys) begin
		if (cold_reset || rom_enable_i)
			count_q <= CNT_W'(TIMEOUT);
		else if (count_q != '0)
			count_q <= count_q - 1'b1;
	end

	assign window_open = (count_q != '0);

	// Sample register
	always_ff @(posedge clk_sys) begin
		if (cold_reset)
			sample_q <= '0;
		else if (vox_we_i && window_open)
			sample_q <= cpu_dout_i;
	end

	assign covox_o = sample_q;

	// Countdown only moves up through a reload
	assert property (@(posedge clk_sys) disable iff (cold_reset)
		(count_q > $past(count_q)) |-> $past(rom_enable_i))
		else $error("covox_dac: timeout counter rose without reload");

endmodule

`default_nettype wire

// ==== logic/vec_io_top.sv ====
`default_nettype none

`include "vec_io_defines.svh"

module vec_io_top #(
	parameter int unsigned COVOX_TIMEOUT = `VEC_COVOX_TIMEOUT
) (
	input logic clk_sys,
	input logic cold_reset,
	input vec_io_pkg::cpu_addr_t addr_i,
	input vec_io_pkg::byte_t cpu_dout_i,
	input logic cpu_sync_i,
	input logic cpu_rd_i,
	input logic cpu_wr_n_i,
	input logic rom_enable_i,
	input vec_io_pkg::byte_t joy_a_i,
	input vec_io_pkg::byte_t joy_b_i,
	output vec_io_pkg::byte_t io_data_o,
	output logic mreq_o,
	output logic int_ack_o,
	output vec_io_pkg::ed_page_t ed_page_o,
	output vec_io_pkg::byte_t covox_o
);

	logic mem_access;
	logic io_stack;
	logic edsk_we;
	logic joy_we;
	logic joy_addr0;
	logic vox_we;
	vec_io_pkg::byte_t joy_p;
	vec_io_pkg::byte_t joy_pu;
	vec_io_pkg::byte_t joy_a_fmt;
	vec_io_pkg::byte_t joy_b_fmt;

	// ------------------------------------------------------------------------
	// Bus control
	// ------------------------------------------------------------------------

	bus_ctrl u_bus_ctrl (
		.clk_sys(clk_sys),
		.cold_reset(cold_reset),
		.addr_i(addr_i),
		.cpu_dout_i(cpu_dout_i),
		.cpu_sync_i(cpu_sync_i),
		.cpu_rd_i(cpu_rd_i),
		.cpu_wr_n_i(cpu_wr_n_i),
		.joy_p_i(joy_p),
		.joy_pu_i(joy_pu),
		.joy_a_fmt_i(joy_a_fmt),
		.joy_b_fmt_i(joy_b_fmt),
		.io_data_o(io_data_o),
		.mreq_o(mreq_o),
		.int_ack_o(int_ack_o),
		.mem_access_o(mem_access),
		.io_stack_o(io_stack),
		.edsk_we_o(edsk_we),
		.joy_we_o(joy_we),
		.joy_addr0_o(joy_addr0),
		.vox_we_o(vox_we)
	);

	// ------------------------------------------------------------------------
	// Port registers
	// ------------------------------------------------------------------------

	edisk_mapper u_edisk_mapper (
		.clk_sys(clk_sys),
		.cold_reset(cold_reset),
		.addr_i(addr_i),
		.cpu_dout_i(cpu_dout_i),
		.edsk_we_i(edsk_we),
		.mem_access_i(mem_access),
		.io_stack_i(io_stack),
		.ed_page_o(ed_page_o)
	);

	joy_ports u_joy_ports (
		.clk_sys(clk_sys),
		.cold_reset(cold_reset),
		.cpu_dout_i(cpu_dout_i),
		.joy_we_i(joy_we),
		.joy_addr0_i(joy_addr0),
		.joy_a_i(joy_a_i),
		.joy_b_i(joy_b_i),
		.joy_p_o(joy_p),
		.joy_pu_o(joy_pu),
		.joy_a_fmt_o(joy_a_fmt),
		.joy_b_fmt_o(joy_b_fmt)
	);

	covox_dac #(
		.TIMEOUT(COVOX_TIMEOUT)
	) u_covox_dac (
		.clk_sys(clk_sys),
		.cold_reset(cold_reset),
		.rom_enable_i(rom_enable_i),
		.cpu_dout_i(cpu_dout_i),
		.vox_we_i(vox_we),
		.covox_o(covox_o)
	);

endmodule

`default_nettype wire

// ==== test/tb_vec_io.sv ====
`default_nettype none

`include "vec_io_defines.svh"

module tb_vec_io;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_LINES = 64;
	localparam int CLK_PERIOD = 20;
	// Bus operation length in clocks, with margin
	localparam int LINE_CYCLES = 8;

	logic clk_sys = 1'b0;
	logic cold_reset;
	vec_io_pkg::cpu_addr_t addr_i;
	vec_io_pkg::byte_t cpu_dout_i;
	logic cpu_sync_i;
	logic cpu_rd_i;
	logic cpu_wr_n_i;
	logic rom_enable_i;
	vec_io_pkg::byte_t joy_a_i;
	vec_io_pkg::byte_t joy_b_i;
	vec_io_pkg::byte_t io_data_o;
	logic mreq_o;
	logic int_ack_o;
	vec_io_pkg::ed_page_t ed_page_o;
	vec_io_pkg::byte_t covox_o;

	// Four words per line: op, address, data, expected
	logic [15:0] stim [0:4*MAX_LINES-1];
	int errors;
	int checks;
	longint watchdog_ns;

	vec_io_top #(
		.COVOX_TIMEOUT(400)
	) uut (
		.clk_sys(clk_sys),
		.cold_reset(cold_reset),
		.addr_i(addr_i),
		.cpu_dout_i(cpu_dout_i),
		.cpu_sync_i(cpu_sync_i),
		.cpu_rd_i(cpu_rd_i),
		.cpu_wr_n_i(cpu_wr_n_i),
		.rom_enable_i(rom_enable_i),
		.joy_a_i(joy_a_i),
		.joy_b_i(joy_b_i),
		.io_data_o(io_data_o),
		.mreq_o(mreq_o),
		.int_ack_o(int_ack_o),
		.ed_page_o(ed_page_o),
		.covox_o(covox_o)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// ------------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------------

	// Write strobes currently high inside the DUT
	function automatic int strobe_count();
		return int'(uut.edsk_we) + int'(uut.joy_we) + int'(uut.vox_we);
	endfunction

	// Ports that own a write register
	function automatic int expected_strobes(input logic [7:0] port);
		if (port == `VEC_JOY_CTRL || port == (`VEC_JOY_CTRL | 8'h01) ||
			port == `VEC_EDSK || port == `VEC_COVOX)
			return 1;
		return 0;
	endfunction

	task automatic compare_byte(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		checks++;
		assert (got == exp)
		else begin
			errors++;
			$display("error at %0d ns: %s = %02h, expected %02h", $time, name, got, exp);
		end
	endtask

	// One line of the stimulus file as a bus operation
	task automatic run_line(input logic [3:0] op, input logic [15:0] addr,
		input logic [7:0] data, input logic [7:0] expected);
		vec_io_pkg::byte_t status;
		int pulses;
		case (op)
			4'h1: status = 8'h10;
			4'h2: status = 8'h42;
			default: status = data;
		endcase
		pulses = 0;
		if (op == 4'h4) begin
			repeat (int'(data) * 8) @(posedge clk_sys);
		end else if (op == 4'h5) begin
			@(posedge clk_sys);
			joy_a_i <= addr[15:8];
			joy_b_i <= addr[7:0];
		end else begin
			@(posedge clk_sys);
			cpu_sync_i <= 1'b1;
			cpu_dout_i <= status;
			addr_i <= addr;
			@(posedge clk_sys);
			cpu_sync_i <= 1'b0;
			if (op == 4'h1) begin
				cpu_dout_i <= data;
				cpu_wr_n_i <= 1'b0;
			end else if (op == 4'h2) begin
				cpu_rd_i <= 1'b1;
			end
			@(posedge clk_sys);
			@(negedge clk_sys);
			pulses += strobe_count();
			@(posedge clk_sys);
			@(negedge clk_sys);
			pulses += strobe_count();
			case (op)
				4'h0: compare_byte("{int_ack_o, mreq_o}", {6'b0, int_ack_o, mreq_o}, expected);
				4'h1: compare_byte("covox_o", covox_o, expected);
				4'h2: compare_byte("io_data_o", io_data_o, expected);
				default: compare_byte("ed_page_o", {5'b0, ed_page_o}, expected);
			endcase
			// Third write cycle, then release the bus
			@(posedge clk_sys);
			cpu_wr_n_i <= 1'b1;
			cpu_rd_i <= 1'b0;
			@(negedge clk_sys);
			pulses += strobe_count();
			if (op == 4'h1)
				compare_byte("write strobe count", 8'(pulses), 8'(expected_strobes(addr[7:0])));
		end
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------

	initial begin
		int line_count;
		longint total_cycles;
		cold_reset = 1'b1;
		addr_i = '0;
		cpu_dout_i = '0;
		cpu_sync_i = 1'b0;
		cpu_rd_i = 1'b0;
		cpu_wr_n_i = 1'b1;
		rom_enable_i = 1'b0;
		joy_a_i = '0;
		joy_b_i = '0;
		errors = 0;
		checks = 0;
		$readmemh("test/vec_io_stimulus.txt", stim);
		line_count = 0;
		total_cycles = 4;
		while (line_count < MAX_LINES && stim[4*line_count] != 16'h000f) begin
			total_cycles += LINE_CYCLES;
			// Idle lines wait data times 8 clocks
			if (stim[4*line_count] == 16'h0004)
				total_cycles += longint'(stim[4*line_count+2]) * 8;
			line_count++;
		end
		watchdog_ns = 2 * total_cycles * CLK_PERIOD;
		if (line_count == 0) begin
			errors++;
			$display("Stimulus file holds no bus operations");
		end
		repeat (4) @(posedge clk_sys);
		cold_reset <= 1'b0;
		for (int i = 0; i < line_count; i++)
			run_line(stim[4*i][3:0], stim[4*i+1], stim[4*i+2][7:0], stim[4*i+3][7:0]);
		$display("Bus operations: %0d, checks: %0d, errors: %0d", line_count, checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		wait (watchdog_ns != 0);
		#(watchdog_ns);
		$display("Watchdog timeout: bus operations did not finish in time");
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/vec_io_stimulus.txt ====
// Columns: op addr data expected, all hex
// Op 0 status, 1 I/O write, 2 I/O read, 3 memory, 4 idle data*8 clocks, 5 sticks A/B, f end
// Ports 04h/05h joystick control, 06h P, 07h PU and Covox, 0Eh A, 0Fh B, 10h E-disk
2 0004 00 00
3 a000 82 00
1 0020 33 00    // Unmapped port, no strobe
0 0000 82 01
0 0000 00 01
0 0000 42 00
0 0000 10 00
0 0000 23 02    // Interrupt acknowledge
1 0007 5a 5a    // Covox inside the write window
1 0010 21 5a    // RAM enable, page bits 01
3 a000 82 02
3 c123 00 02
3 8000 82 00
3 4000 82 00
1 0010 e6 5a    // Both extra windows, page bits 10
3 8000 82 03
3 f000 82 03
3 b000 86 03
1 0010 3d 5a    // Stack and RAM enable
3 a000 86 04
3 fffe 04 04
3 a000 82 02
3 a000 42 00
5 2905 00 00    // A Fire2 Up Right, B Down Right
2 000e 00 76
2 000f 00 fa
2 0006 00 72
2 0007 00 e4
1 0005 20 5a    // P port shows stick A
2 0006 00 76
1 0004 0d 5a    // Set bit 6
2 0006 00 ff
1 0004 0a 5a    // Clear bit 5
2 0006 00 fa
1 0004 8b 5a    // Bit 7 set, ignored
2 0006 00 fa
2 0010 00 ff
2 120e 00 76
4 0000 40 00    // Let the Covox window close
1 0007 a5 5a
f 0000 00 00

// ==== tb.f ====
+incdir+logic
logic/vec_io_pkg.sv
logic/bus_ctrl.sv
logic/edisk_mapper.sv
logic/joy_ports.sv
logic/covox_dac.sv
logic/vec_io_top.sv
test/tb_vec_io.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the vec_io testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_vec_io -f tb.f -Mdir "$BUILD_DIR"

"./$BUILD_DIR/Vtb_vec_io" | tee "$LOG_FILE"

if grep -q "ALL TESTS PASSED" "$LOG_FILE"; then
	exit 0
else
	exit 1
fi
